/* logic/vec_exec_pkg.sv */
// vector execute shared definitions
package vec_exec_pkg;

  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;

  typedef enum logic [2:0] {
    VALU_ADD,
    VALU_AND,
    VALU_OR,
    VALU_XOR,
    VALU_MIN,
    VALU_MINU,
    VALU_MAX,
    VALU_MAXU
  } aluop_t;

  // operand source: per-lane vector, immediate, scalar register
  typedef enum logic [1:0] {V, I, X} src_t;

  typedef enum logic [1:0] {SEW8, SEW16, SEW32} sew_t;

  typedef enum logic [1:0] {NONE, LOAD, STORE} memop_t;

  // byte stride when the stride field is zero
  localparam word_t DEFAULT_STRIDE = 32'd4;

  // element-wise rule, shared by the lanes and the reduction combine
  function automatic word_t alu_eval(aluop_t op, sew_t sew, word_t a, word_t b);
    logic lt_s;
    logic lt_u;
    // signed compare looks only at the low element bits
    case (sew)
      SEW8:    lt_s = $signed(a[7:0]) < $signed(b[7:0]);
      SEW16:   lt_s = $signed(a[15:0]) < $signed(b[15:0]);
      default: lt_s = $signed(a) < $signed(b);
    endcase
    lt_u = a < b;
    case (op)
      VALU_ADD:  alu_eval = a + b;
      VALU_AND:  alu_eval = a & b;
      VALU_OR:   alu_eval = a | b;
      VALU_XOR:  alu_eval = a ^ b;
      VALU_MIN:  alu_eval = lt_s ? a : b;
      VALU_MINU: alu_eval = lt_u ? a : b;
      VALU_MAX:  alu_eval = lt_s ? b : a;
      VALU_MAXU: alu_eval = lt_u ? b : a;
      default:   alu_eval = '0;
    endcase
  endfunction

endpackage

/* logic/vector_lane.sv */
// vector lane execute unit
`timescale 1ns/1ps

module vector_lane #(
  parameter int LANE_ID   = 0,
  parameter int MEM_WORDS = 16
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 start,
  input  vec_exec_pkg::word_t  opa,
  input  vec_exec_pkg::word_t  opb,
  input  vec_exec_pkg::aluop_t aluop,
  input  vec_exec_pkg::sew_t   sew,
  input  vec_exec_pkg::memop_t memop,
  input  vec_exec_pkg::word_t  base,
  input  vec_exec_pkg::word_t  stride,
  input  vec_exec_pkg::word_t  wdata,
  input  logic                 mack,
  input  vec_exec_pkg::word_t  mrdata,
  output vec_exec_pkg::word_t  lane_result,
  output logic                 done,
  output logic                 mreq,
  output logic                 mwe,
  output vec_exec_pkg::word_t  maddr,
  output vec_exec_pkg::word_t  mwdata
);

  import vec_exec_pkg::*;

  typedef enum logic [1:0] {L_IDLE, L_REQ, L_RELEASE} lane_state_t;

  lane_state_t state;
  word_t       stride_eff;
  word_t       byte_addr;
  word_t       word_idx;

  // lane n sits n strides above the base
  assign stride_eff = (stride == '0) ? DEFAULT_STRIDE : stride;
  assign byte_addr  = base + stride_eff * word_t'(LANE_ID);
  // word index wraps around the memory depth
  assign word_idx   = (byte_addr >> 2) % word_t'(MEM_WORDS);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= L_IDLE;
      mreq  <= 1'b0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        L_IDLE: begin
          if (start) begin
            if (memop == NONE) begin
              done <= 1'b1;
            end else begin
              mreq  <= 1'b1;
              state <= L_REQ;
            end
          end
        end
        // hold the request until the arbiter acks
        L_REQ: begin
          if (mack) begin
            mreq  <= 1'b0;
            state <= L_RELEASE;
          end
        end
        L_RELEASE: begin
          if (!mack) begin
            done  <= 1'b1;
            state <= L_IDLE;
          end
        end
        default: state <= L_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      // stores report their byte address
      if (memop == NONE) begin
        lane_result <= alu_eval(aluop, sew, opa, opb);
      end else begin
        lane_result <= byte_addr;
      end
      maddr  <= word_idx;
      mwe    <= (memop == STORE);
      mwdata <= wdata;
    end else if (state == L_REQ && mack && !mwe) begin
      lane_result <= mrdata;
    end
  end

endmodule

/* logic/mem_arbiter.sv */
// round-robin memory arbiter
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                mreq0,
  input  logic                mwe0,
  input  vec_exec_pkg::word_t maddr0,
  input  vec_exec_pkg::word_t mwdata0,
  input  logic                mreq1,
  input  logic                mwe1,
  input  vec_exec_pkg::word_t maddr1,
  input  vec_exec_pkg::word_t mwdata1,
  input  logic                ack,
  input  vec_exec_pkg::word_t rdata,
  output logic                mack0,
  output logic                mack1,
  output vec_exec_pkg::word_t mrdata,
  output logic                req,
  output logic                we,
  output vec_exec_pkg::word_t addr,
  output vec_exec_pkg::word_t wdata
);

  import vec_exec_pkg::*;

  logic busy;
  logic gnt;
  logic last;
  logic pick;

  // both waiting, so serve the lane not served last
  assign pick = (mreq0 && mreq1) ? ~last : mreq1;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy <= 1'b0;
      gnt  <= 1'b0;
      last <= 1'b1;
    end else if (!busy) begin
      if (mreq0 || mreq1) begin
        busy <= 1'b1;
        gnt  <= pick;
      end
    end else if (!req && !ack) begin
      // granted handshake back at idle
      busy <= 1'b0;
      last <= gnt;
    end
  end

  assign req    = busy & (gnt ? mreq1 : mreq0);
  assign we     = gnt ? mwe1 : mwe0;
  assign addr   = gnt ? maddr1 : maddr0;
  assign wdata  = gnt ? mwdata1 : mwdata0;
  assign mack0  = busy & ~gnt & ack;
  assign mack1  = busy & gnt & ack;
  assign mrdata = rdata;

endmodule

/* logic/lane_memory.sv */
// shared word memory
`timescale 1ns/1ps

module lane_memory #(
  parameter int MEM_WORDS = 16
) (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                req,
  input  logic                we,
  input  vec_exec_pkg::word_t addr,
  input  vec_exec_pkg::word_t wdata,
  output logic                ack,
  output vec_exec_pkg::word_t rdata
);

  import vec_exec_pkg::*;

  localparam int AW = $clog2(MEM_WORDS);

  word_t         mem [MEM_WORDS];
  logic [AW-1:0] idx;

  // addr already carries a wrapped word index
  assign idx = addr[AW-1:0];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ack <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (req && !ack) begin
      ack <= 1'b1;
      if (we) begin
        mem[idx] <= wdata;
      end
    end else if (!req && ack) begin
      ack <= 1'b0;
    end
  end

  // read data appears together with ack
  always_ff @(posedge CLK) begin
    if (req && !ack && !we) begin
      rdata <= mem[idx];
    end
  end

endmodule

/* logic/exec_sequencer.sv */
// execute op sequencer
`timescale 1ns/1ps

module exec_sequencer (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 op_req,
  input  vec_exec_pkg::aluop_t aluop,
  input  vec_exec_pkg::src_t   src1,
  input  vec_exec_pkg::src_t   src2,
  input  vec_exec_pkg::sew_t   sew,
  input  logic                 reduce,
  input  vec_exec_pkg::word_t  vs1_lane0,
  input  vec_exec_pkg::word_t  vs1_lane1,
  input  vec_exec_pkg::word_t  vs2_lane0,
  input  vec_exec_pkg::word_t  vs2_lane1,
  input  vec_exec_pkg::word_t  xs1,
  input  vec_exec_pkg::word_t  xs2,
  input  vec_exec_pkg::word_t  imm,
  input  vec_exec_pkg::word_t  lane_result0,
  input  vec_exec_pkg::word_t  lane_result1,
  input  logic                 done0,
  input  logic                 done1,
  output logic                 op_ack,
  output vec_exec_pkg::word_t  result0,
  output vec_exec_pkg::word_t  result1,
  output logic                 start,
  output vec_exec_pkg::word_t  opa0,
  output vec_exec_pkg::word_t  opb0,
  output vec_exec_pkg::word_t  opa1,
  output vec_exec_pkg::word_t  opb1
);

  import vec_exec_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_BUSY, S_ACK} seq_state_t;

  seq_state_t state;
  logic       got0;
  logic       got1;
  logic       all_done;
  word_t      res0_q;
  word_t      res1_q;
  word_t      res0_n;
  word_t      res1_n;

  function automatic word_t select_op(src_t src, word_t vec, word_t scalar, word_t imm_val);
    case (src)
      V:       select_op = vec;
      I:       select_op = imm_val;
      X:       select_op = scalar;
      default: select_op = '0;
    endcase
  endfunction

  // I and X sources broadcast to both lanes
  assign opa0 = select_op(src1, vs1_lane0, xs1, imm);
  assign opa1 = select_op(src1, vs1_lane1, xs1, imm);
  assign opb0 = select_op(src2, vs2_lane0, xs2, imm);
  assign opb1 = select_op(src2, vs2_lane1, xs2, imm);

  // a done pulse this cycle counts as already collected
  assign res0_n   = done0 ? lane_result0 : res0_q;
  assign res1_n   = done1 ? lane_result1 : res1_q;
  assign all_done = (got0 | done0) & (got1 | done1);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state  <= S_IDLE;
      start  <= 1'b0;
      op_ack <= 1'b0;
      got0   <= 1'b0;
      got1   <= 1'b0;
    end else begin
      start <= 1'b0;
      case (state)
        S_IDLE: begin
          if (op_req) begin
            start <= 1'b1;
            got0  <= 1'b0;
            got1  <= 1'b0;
            state <= S_BUSY;
          end
        end
        S_BUSY: begin
          got0 <= got0 | done0;
          got1 <= got1 | done1;
          if (all_done) begin
            op_ack <= 1'b1;
            state  <= S_ACK;
          end
        end
        S_ACK: begin
          if (!op_req) begin
            op_ack <= 1'b0;
            state  <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (done0) begin
      res0_q <= lane_result0;
    end
    if (done1) begin
      res1_q <= lane_result1;
    end
    if (state == S_BUSY && all_done) begin
      result0 <= reduce ? alu_eval(aluop, sew, res0_n, res1_n) : res0_n;
      result1 <= res1_n;
    end
  end

endmodule

/* logic/vec_execute_top.sv */
// two-lane vector execute block
`timescale 1ns/1ps

module vec_execute_top #(
  parameter int MEM_WORDS = 16
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 op_req,
  input  vec_exec_pkg::aluop_t aluop,
  input  vec_exec_pkg::src_t   src1,
  input  vec_exec_pkg::src_t   src2,
  input  vec_exec_pkg::sew_t   sew,
  input  vec_exec_pkg::memop_t memop,
  input  logic                 reduce,
  input  vec_exec_pkg::word_t  vs1_lane0,
  input  vec_exec_pkg::word_t  vs1_lane1,
  input  vec_exec_pkg::word_t  vs2_lane0,
  input  vec_exec_pkg::word_t  vs2_lane1,
  input  vec_exec_pkg::word_t  xs1,
  input  vec_exec_pkg::word_t  xs2,
  input  vec_exec_pkg::word_t  imm,
  input  vec_exec_pkg::word_t  stride,
  input  vec_exec_pkg::word_t  storedata0,
  input  vec_exec_pkg::word_t  storedata1,
  output logic                 op_ack,
  output vec_exec_pkg::word_t  result0,
  output vec_exec_pkg::word_t  result1
);

  import vec_exec_pkg::*;

  logic  start;
  logic  done0, done1;
  word_t opa0, opb0, opa1, opb1;
  word_t lane_result0, lane_result1;
  logic  mreq0, mwe0, mack0;
  logic  mreq1, mwe1, mack1;
  word_t maddr0, mwdata0, maddr1, mwdata1, mrdata;
  logic  req, we, ack;
  word_t addr, wdata, rdata;

  exec_sequencer u_seq (
    .CLK(CLK), .nRST(nRST), .op_req(op_req), .aluop(aluop),
    .src1(src1), .src2(src2), .sew(sew), .reduce(reduce),
    .vs1_lane0(vs1_lane0), .vs1_lane1(vs1_lane1),
    .vs2_lane0(vs2_lane0), .vs2_lane1(vs2_lane1),
    .xs1(xs1), .xs2(xs2), .imm(imm),
    .lane_result0(lane_result0), .lane_result1(lane_result1),
    .done0(done0), .done1(done1), .op_ack(op_ack),
    .result0(result0), .result1(result1), .start(start),
    .opa0(opa0), .opb0(opb0), .opa1(opa1), .opb1(opb1)
  );

  // base address is the scalar xs1
  vector_lane #(.LANE_ID(0), .MEM_WORDS(MEM_WORDS)) u_lane0 (
    .CLK(CLK), .nRST(nRST), .start(start), .opa(opa0), .opb(opb0),
    .aluop(aluop), .sew(sew), .memop(memop), .base(xs1), .stride(stride),
    .wdata(storedata0), .mack(mack0), .mrdata(mrdata),
    .lane_result(lane_result0), .done(done0), .mreq(mreq0), .mwe(mwe0),
    .maddr(maddr0), .mwdata(mwdata0)
  );

  vector_lane #(.LANE_ID(1), .MEM_WORDS(MEM_WORDS)) u_lane1 (
    .CLK(CLK), .nRST(nRST), .start(start), .opa(opa1), .opb(opb1),
    .aluop(aluop), .sew(sew), .memop(memop), .base(xs1), .stride(stride),
    .wdata(storedata1), .mack(mack1), .mrdata(mrdata),
    .lane_result(lane_result1), .done(done1), .mreq(mreq1), .mwe(mwe1),
    .maddr(maddr1), .mwdata(mwdata1)
  );

  mem_arbiter u_arb (
    .CLK(CLK), .nRST(nRST),
    .mreq0(mreq0), .mwe0(mwe0), .maddr0(maddr0), .mwdata0(mwdata0),
    .mreq1(mreq1), .mwe1(mwe1), .maddr1(maddr1), .mwdata1(mwdata1),
    .ack(ack), .rdata(rdata), .mack0(mack0), .mack1(mack1), .mrdata(mrdata),
    .req(req), .we(we), .addr(addr), .wdata(wdata)
  );

  lane_memory #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .CLK(CLK), .nRST(nRST), .req(req), .we(we), .addr(addr),
    .wdata(wdata), .ack(ack), .rdata(rdata)
  );

endmodule

/* sim/vec_execute_checker.sv */
// execute handshake assertions
`timescale 1ns/1ps

module vec_execute_checker (
  input logic CLK,
  input logic nRST,
  input logic op_req,
  input logic op_ack,
  input logic mreq0,
  input logic mreq1,
  input logic mack0,
  input logic mack1
);

  // ack answers a live request only
  op_ack_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(op_ack) |-> op_req)
    else $error("op_ack rose while op_req was low");

  // one lane served at a time
  mack_onehot: assert property (@(posedge CLK) disable iff (!nRST)
    !(mack0 && mack1))
    else $error("mack0 and mack1 high together");

  // requests are held until acknowledged
  mreq0_held: assert property (@(posedge CLK) disable iff (!nRST)
    (mreq0 && !mack0) |=> mreq0)
    else $error("lane 0 dropped mreq before mack");

  mreq1_held: assert property (@(posedge CLK) disable iff (!nRST)
    (mreq1 && !mack1) |=> mreq1)
    else $error("lane 1 dropped mreq before mack");

endmodule

/* sim/vec_execute_tb.sv */
// vector execute testbench
`timescale 1ns/1ps

module vec_execute_tb;

  import vec_exec_pkg::*;

  localparam int MEM_WORDS = 16;
  localparam int CLK_NS    = 8;

  typedef struct packed {
    aluop_t aluop;
    src_t   src1;
    src_t   src2;
    sew_t   sew;
    memop_t memop;
    logic   reduce;
    word_t  vs1_0, vs1_1, vs2_0, vs2_1;
    word_t  xs1, xs2, imm, stride;
    word_t  sd0, sd1;
    word_t  exp0, exp1;
  } op_entry_t;

  logic   CLK;
  logic   nRST;
  logic   op_req;
  logic   reduce;
  aluop_t aluop;
  src_t   src1, src2;
  sew_t   sew;
  memop_t memop;
  word_t  vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1;
  word_t  xs1, xs2, imm, stride;
  word_t  storedata0, storedata1;
  logic   op_ack;
  word_t  result0, result1;

  op_entry_t tbl [$];
  word_t     mem_model [MEM_WORDS];
  integer    seed;
  logic      table_ready = 1'b0;

  vec_execute_top #(.MEM_WORDS(MEM_WORDS)) DUT (
    .CLK(CLK), .nRST(nRST), .op_req(op_req), .aluop(aluop),
    .src1(src1), .src2(src2), .sew(sew), .memop(memop), .reduce(reduce),
    .vs1_lane0(vs1_lane0), .vs1_lane1(vs1_lane1),
    .vs2_lane0(vs2_lane0), .vs2_lane1(vs2_lane1),
    .xs1(xs1), .xs2(xs2), .imm(imm), .stride(stride),
    .storedata0(storedata0), .storedata1(storedata1),
    .op_ack(op_ack), .result0(result0), .result1(result1)
  );

  bind vec_execute_top vec_execute_checker chk (
    .CLK(CLK), .nRST(nRST), .op_req(op_req), .op_ack(op_ack),
    .mreq0(mreq0), .mreq1(mreq1), .mack0(mack0), .mack1(mack1)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_NS / 2) CLK = ~CLK;
  end

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR @%0d ns: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR @%0d ns: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  // sign-extended view of the low element bits
  function automatic logic signed [31:0] elem_signed(sew_t s, word_t w);
    case (s)
      SEW8:    elem_signed = {{24{w[7]}}, w[7:0]};
      SEW16:   elem_signed = {{16{w[15]}}, w[15:0]};
      default: elem_signed = w;
    endcase
  endfunction

  function automatic word_t ref_alu(aluop_t op, sew_t s, word_t a, word_t b);
    logic a_lt;
    logic a_ltu;
    a_lt  = elem_signed(s, a) < elem_signed(s, b);
    a_ltu = a < b;
    case (op)
      VALU_ADD:  ref_alu = a + b;
      VALU_AND:  ref_alu = a & b;
      VALU_OR:   ref_alu = a | b;
      VALU_XOR:  ref_alu = a ^ b;
      VALU_MIN:  ref_alu = a_lt ? a : b;
      VALU_MINU: ref_alu = a_ltu ? a : b;
      VALU_MAX:  ref_alu = a_lt ? b : a;
      default:   ref_alu = a_ltu ? b : a;
    endcase
  endfunction

  function automatic word_t pick_operand(src_t s, word_t vec, word_t scalar, word_t im);
    if (s == V) begin
      pick_operand = vec;
    end else if (s == I) begin
      pick_operand = im;
    end else begin
      pick_operand = scalar;
    end
  endfunction

  // byte address of a lane, zero stride meaning one word
  function automatic word_t lane_addr(word_t base_addr, word_t strd, int lane);
    word_t step;
    step      = (strd == 32'h0) ? 32'd4 : strd;
    lane_addr = base_addr + step * lane;
  endfunction

  function automatic int word_index(word_t byte_addr);
    word_index = int'((byte_addr / 4) % MEM_WORDS);
  endfunction

  task automatic add_alu(aluop_t op, src_t s1, src_t s2, sew_t s, logic red,
                         word_t a0, word_t a1, word_t b0, word_t b1,
                         word_t x1, word_t x2, word_t im);
    op_entry_t e;
    word_t     r0;
    word_t     r1;
    e        = '0;
    e.aluop  = op;
    e.src1   = s1;
    e.src2   = s2;
    e.sew    = s;
    e.reduce = red;
    e.vs1_0  = a0;
    e.vs1_1  = a1;
    e.vs2_0  = b0;
    e.vs2_1  = b1;
    e.xs1    = x1;
    e.xs2    = x2;
    e.imm    = im;
    r0 = ref_alu(op, s, pick_operand(s1, a0, x1, im), pick_operand(s2, b0, x2, im));
    r1 = ref_alu(op, s, pick_operand(s1, a1, x1, im), pick_operand(s2, b1, x2, im));
    e.exp0 = red ? ref_alu(op, s, r0, r1) : r0;
    e.exp1 = r1;
    tbl.push_back(e);
  endtask

  task automatic add_mem(memop_t mop, word_t base_addr, word_t strd, word_t d0, word_t d1);
    op_entry_t e;
    word_t     a0;
    word_t     a1;
    e        = '0;
    e.memop  = mop;
    e.xs1    = base_addr;
    e.stride = strd;
    e.sd0    = d0;
    e.sd1    = d1;
    a0 = lane_addr(base_addr, strd, 0);
    a1 = lane_addr(base_addr, strd, 1);
    if (mop == STORE) begin
      mem_model[word_index(a0)] = d0;
      mem_model[word_index(a1)] = d1;
      e.exp0 = a0;
      e.exp1 = a1;
    end else begin
      e.exp0 = mem_model[word_index(a0)];
      e.exp1 = mem_model[word_index(a1)];
    end
    tbl.push_back(e);
  endtask

  task automatic build_table();
    word_t r;
    word_t base_r;
    word_t stride_r;
    foreach (mem_model[k]) begin
      mem_model[k] = 32'h0;
    end
    // every alu op on per-lane vectors
    for (int k = 0; k < 8; k++) begin
      add_alu(aluop_t'(3'(k)), V, V, SEW32, 1'b0, 32'h0000_1234, 32'h8000_0001,
              32'h0000_00ff, 32'h7fff_fff0, 32'h0, 32'h0, 32'h0);
    end
    // scalar and immediate broadcast
    add_alu(VALU_ADD, X, I, SEW32, 1'b0, 32'h0, 32'h0, 32'h0, 32'h0,
            32'h0000_1000, 32'h0, 32'h0000_0023);
    add_alu(VALU_XOR, I, X, SEW32, 1'b0, 32'h0, 32'h0, 32'h0, 32'h0,
            32'h0, 32'hff00_ff00, 32'h0f0f_0f0f);
    // low bits negative while the full word is positive, and the reverse
    add_alu(VALU_MIN, X, I, SEW8, 1'b0, 32'h0, 32'h0, 32'h0, 32'h0,
            32'h0000_0080, 32'h0, 32'hffff_ff01);
    add_alu(VALU_MAX, V, X, SEW16, 1'b0, 32'h0001_8000, 32'h0000_7fff, 32'h0, 32'h0,
            32'h0, 32'hffff_0001, 32'h0);
    add_alu(VALU_MIN, I, V, SEW16, 1'b0, 32'h0, 32'h0, 32'h0000_8001, 32'hffff_7ffe,
            32'h0, 32'h0, 32'h7fff_0005);
    // reductions over both lanes
    add_alu(VALU_ADD, V, V, SEW32, 1'b1, 32'h0000_0010, 32'h0000_0020, 32'h1, 32'h2,
            32'h0, 32'h0, 32'h0);
    add_alu(VALU_MAXU, V, X, SEW32, 1'b1, 32'h9000_0000, 32'h1000_0000, 32'h0, 32'h0,
            32'h0, 32'h8000_0000, 32'h0);
    add_alu(VALU_MIN, V, V, SEW8, 1'b1, 32'h0000_0090, 32'h0000_0070, 32'hffff_ff05,
            32'h0000_0181, 32'h0, 32'h0, 32'h0);
    // store then load, default stride and stride 8
    add_mem(STORE, 32'h10, 32'h0, 32'hcafe_0001, 32'hcafe_0002);
    add_mem(LOAD, 32'h10, 32'h0, 32'h0, 32'h0);
    add_mem(STORE, 32'h20, 32'h8, 32'h1111_aaaa, 32'h2222_bbbb);
    add_mem(LOAD, 32'h20, 32'h8, 32'h0, 32'h0);
    // lane 1 wraps from the last word to word 0
    add_mem(STORE, 32'h3c, 32'h0, 32'h5a5a_0f0f, 32'ha5a5_f0f0);
    add_mem(LOAD, 32'h3c, 32'h0, 32'h0, 32'h0);
    for (int k = 0; k < 6; k++) begin
      r = $random(seed);
      add_alu(aluop_t'(r[2:0]), V, V, sew_t'(r[4:3] % 2'd3), r[5],
              $random(seed), $random(seed), $random(seed), $random(seed),
              32'h0, 32'h0, 32'h0);
    end
    for (int k = 0; k < 2; k++) begin
      r        = $random(seed);
      base_r   = r & 32'h0000_00ff;
      stride_r = word_t'({r[9:8], 2'b00});
      add_mem(STORE, base_r, stride_r, $random(seed), $random(seed));
      add_mem(LOAD, base_r, stride_r, 32'h0, 32'h0);
      add_mem(LOAD, base_r + 32'h8, 32'h4, 32'h0, 32'h0);
    end
  endtask

  task automatic run_entry(int n);
    op_entry_t e;
    int        wait_cycles;
    e = tbl[n];
    @(posedge CLK);
    op_req     <= 1'b1;
    aluop      <= e.aluop;
    src1       <= e.src1;
    src2       <= e.src2;
    sew        <= e.sew;
    memop      <= e.memop;
    reduce     <= e.reduce;
    vs1_lane0  <= e.vs1_0;
    vs1_lane1  <= e.vs1_1;
    vs2_lane0  <= e.vs2_0;
    vs2_lane1  <= e.vs2_1;
    xs1        <= e.xs1;
    xs2        <= e.xs2;
    imm        <= e.imm;
    stride     <= e.stride;
    storedata0 <= e.sd0;
    storedata1 <= e.sd1;
    // wait for the acknowledge with results
    @(negedge CLK);
    while (op_ack !== 1'b1) begin
      @(negedge CLK);
    end
    check_word($sformatf("result0 (op %0d)", n), result0, e.exp0);
    check_word($sformatf("result1 (op %0d)", n), result1, e.exp1);
    @(posedge CLK);
    op_req <= 1'b0;
    wait_cycles = 0;
    @(negedge CLK);
    while (op_ack && wait_cycles < 4) begin
      @(negedge CLK);
      wait_cycles++;
    end
    if (op_ack) begin
      abort_run($sformatf("op_ack stayed high after op_req fell in operation %0d", n));
    end
  endtask

  initial begin
    wait (table_ready);
    repeat (tbl.size() * 200 + 20) @(posedge CLK);
    abort_run("timeout: the operation table did not complete in time");
  end

  initial begin
    seed       = 32'h409f_f90b;
    nRST       = 1'b0;
    op_req     = 1'b0;
    aluop      = VALU_ADD;
    src1       = V;
    src2       = V;
    sew        = SEW32;
    memop      = NONE;
    reduce     = 1'b0;
    vs1_lane0  = 32'h0;
    vs1_lane1  = 32'h0;
    vs2_lane0  = 32'h0;
    vs2_lane1  = 32'h0;
    xs1        = 32'h0;
    xs2        = 32'h0;
    imm        = 32'h0;
    stride     = 32'h0;
    storedata0 = 32'h0;
    storedata1 = 32'h0;
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_bit("op_ack", op_ack, 1'b0);
    foreach (tbl[n]) begin
      run_entry(n);
    end
    repeat (2) @(posedge CLK);
    $display("Everything OK");
    $finish;
  end

endmodule

/* verilog.f */
logic/vec_exec_pkg.sv
logic/vector_lane.sv
logic/mem_arbiter.sv
logic/lane_memory.sv
logic/exec_sequencer.sv
logic/vec_execute_top.sv
sim/vec_execute_checker.sv
sim/vec_execute_tb.sv

/* Makefile */
TOP = vec_execute_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f verilog.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Something failed" sim.log; then exit 1; fi
	@grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
